// ==== rtl/mem_pkg.sv ====
`default_nettype none

package mem_pkg;

	// word and address width
	localparam int WORD_W     = 16;
	localparam int LINE_WORDS = 4;
	localparam int OFFSET_W   = 2;
	localparam int INDEX_W    = 3;
	localparam int TAG_W      = 11;
	localparam int NUM_LINES  = 1 << INDEX_W;

	// address is tag | index | word offset
	localparam int INDEX_LSB = OFFSET_W;
	localparam int TAG_LSB   = OFFSET_W + INDEX_W;

	typedef logic [WORD_W-1:0]            word_t;
	typedef logic [LINE_WORDS*WORD_W-1:0] line_t;
	typedef logic [TAG_W-1:0]             tag_t;
	typedef logic [INDEX_W-1:0]           index_t;
	typedef logic [OFFSET_W-1:0]          offset_t;

	// read level held until the line comes back
	typedef struct packed {
		logic  read;
		word_t addr;
	} line_rd_req_t;

	// write level held until the ack
	typedef struct packed {
		logic  write;
		word_t addr;
		word_t data;
	} word_wr_req_t;

	typedef enum logic [1:0] {
		ST_IDLE,
		ST_LOOKUP,
		ST_REFILL,
		ST_WRITE
	} cache_state_e;

	function automatic tag_t addr_tag(word_t addr);
		return addr[TAG_LSB +: TAG_W];
	endfunction

	function automatic index_t addr_index(word_t addr);
		return addr[INDEX_LSB +: INDEX_W];
	endfunction

	function automatic offset_t addr_offset(word_t addr);
		return addr[OFFSET_W-1:0];
	endfunction

	// first word of the line holding addr
	function automatic word_t line_base(word_t addr);
		return {addr[WORD_W-1:OFFSET_W], {OFFSET_W{1'b0}}};
	endfunction

	// word 0 sits in the low bits
	function automatic word_t line_word(line_t line, offset_t off);
		return line[off*WORD_W +: WORD_W];
	endfunction

	function automatic line_t line_merge(line_t line, offset_t off, word_t data);
		line_t merged;
		merged = line;
		merged[off*WORD_W +: WORD_W] = data;
		return merged;
	endfunction

endpackage

`default_nettype wire

// ==== rtl/instr_cache.sv ====
`timescale 1ns/1ps
`default_nettype none

module instr_cache (
	input  wire                          clk,
	input  wire                          i_rst_n,
	input  wire                          i_fetch_read,
	input  wire mem_pkg::word_t          i_fetch_addr,
	output logic                         o_fetch_ready,
	output mem_pkg::word_t               o_fetch_data,
	output mem_pkg::line_rd_req_t        o_line_req,
	input  wire                          i_line_ready,
	input  wire mem_pkg::line_t          i_line
);

	import mem_pkg::*;

	cache_state_e         state;
	word_t                req_addr;
	logic [NUM_LINES-1:0] valid;
	tag_t                 tags  [NUM_LINES];
	line_t                lines [NUM_LINES];

	index_t               req_index;
	logic                 hit;

	assign req_index = addr_index(req_addr);
	assign hit       = valid[req_index] && (tags[req_index] == addr_tag(req_addr));

	// control FSM, ready is a one-cycle pulse
	always_ff @(posedge clk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			state         <= ST_IDLE;
			valid         <= '0;
			o_fetch_ready <= 1'b0;
			o_line_req    <= '0;
		end else begin
			o_fetch_ready <= 1'b0;
			case (state)
				ST_IDLE: begin
					if (i_fetch_read) begin
						state <= ST_LOOKUP;
					end
				end
				ST_LOOKUP: begin
					if (hit) begin
						o_fetch_ready <= 1'b1;
						state         <= ST_IDLE;
					end else begin
						// miss, fetch the whole aligned line
						o_line_req <= '{read: 1'b1, addr: line_base(req_addr)};
						state      <= ST_REFILL;
					end
				end
				ST_REFILL: begin
					if (i_line_ready) begin
						o_line_req.read  <= 1'b0;
						valid[req_index] <= 1'b1;
						o_fetch_ready    <= 1'b1;
						state            <= ST_IDLE;
					end
				end
				default: begin
					state <= ST_IDLE;
				end
			endcase
		end
	end

	// address latch, line storage and returned word
	always_ff @(posedge clk) begin
		if (state == ST_IDLE && i_fetch_read) begin
			req_addr <= i_fetch_addr;
		end
		if (state == ST_LOOKUP && hit) begin
			o_fetch_data <= line_word(lines[req_index], addr_offset(req_addr));
		end
		if (state == ST_REFILL && i_line_ready) begin
			lines[req_index] <= i_line;
			tags[req_index]  <= addr_tag(req_addr);
			// answer straight from the incoming line
			o_fetch_data     <= line_word(i_line, addr_offset(req_addr));
		end
	end

	// a ready pulse always answers a fetch that was held through the lookup
	a_ready_has_fetch: assert property (@(posedge clk) disable iff (!i_rst_n)
		o_fetch_ready |-> $past(i_fetch_read));

endmodule

`default_nettype wire

// ==== rtl/data_cache.sv ====
`timescale 1ns/1ps
`default_nettype none

module data_cache (
	input  wire                          clk,
	input  wire                          i_rst_n,
	input  wire                          i_data_read,
	input  wire                          i_data_write,
	input  wire mem_pkg::word_t          i_data_addr,
	input  wire mem_pkg::word_t          i_data_wdata,
	output logic                         o_data_ready,
	output mem_pkg::word_t               o_data_rdata,
	output logic                         o_data_ack,
	output mem_pkg::line_rd_req_t        o_line_req,
	input  wire                          i_line_ready,
	input  wire mem_pkg::line_t          i_line,
	output mem_pkg::word_wr_req_t        o_wr_req,
	input  wire                          i_wr_ack
);

	import mem_pkg::*;

	cache_state_e         state;
	word_t                req_addr;
	word_t                req_wdata;
	logic                 req_write;
	logic [NUM_LINES-1:0] valid;
	tag_t                 tags  [NUM_LINES];
	line_t                lines [NUM_LINES];

	index_t               req_index;
	offset_t              req_offset;
	logic                 hit;

	assign req_index  = addr_index(req_addr);
	assign req_offset = addr_offset(req_addr);
	assign hit        = valid[req_index] && (tags[req_index] == addr_tag(req_addr));

	always_ff @(posedge clk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			state        <= ST_IDLE;
			valid        <= '0;
			o_data_ready <= 1'b0;
			o_data_ack   <= 1'b0;
			o_line_req   <= '0;
			o_wr_req     <= '0;
		end else begin
			o_data_ready <= 1'b0;
			o_data_ack   <= 1'b0;
			case (state)
				ST_IDLE: begin
					if (i_data_read || i_data_write) begin
						state <= ST_LOOKUP;
					end
				end
				ST_LOOKUP: begin
					if (req_write) begin
						// write-through, hit or miss
						o_wr_req <= '{write: 1'b1, addr: req_addr, data: req_wdata};
						state    <= ST_WRITE;
					end else if (hit) begin
						o_data_ready <= 1'b1;
						state        <= ST_IDLE;
					end else begin
						o_line_req <= '{read: 1'b1, addr: line_base(req_addr)};
						state      <= ST_REFILL;
					end
				end
				ST_REFILL: begin
					if (i_line_ready) begin
						o_line_req.read  <= 1'b0;
						valid[req_index] <= 1'b1;
						o_data_ready     <= 1'b1;
						state            <= ST_IDLE;
					end
				end
				ST_WRITE: begin
					// ack only once memory has taken the word
					if (i_wr_ack) begin
						o_wr_req.write <= 1'b0;
						o_data_ack     <= 1'b1;
						state          <= ST_IDLE;
					end
				end
				default: begin
					state <= ST_IDLE;
				end
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (state == ST_IDLE && (i_data_read || i_data_write)) begin
			req_addr  <= i_data_addr;
			req_wdata <= i_data_wdata;
			req_write <= i_data_write;
		end
		if (state == ST_LOOKUP && hit) begin
			if (req_write) begin
				// keep the cached copy in step with memory
				lines[req_index] <= line_merge(lines[req_index], req_offset, req_wdata);
			end else begin
				o_data_rdata <= line_word(lines[req_index], req_offset);
			end
		end
		if (state == ST_REFILL && i_line_ready) begin
			lines[req_index] <= i_line;
			tags[req_index]  <= addr_tag(req_addr);
			o_data_rdata     <= line_word(i_line, req_offset);
		end
	end

	// one request in flight, so a refill and a write never overlap
	a_one_port_busy: assert property (@(posedge clk) disable iff (!i_rst_n)
		!(o_line_req.read && o_wr_req.write));

endmodule

`default_nettype wire

// ==== rtl/mem_port_arbiter.sv ====
`timescale 1ns/1ps
`default_nettype none

module mem_port_arbiter (
	input  wire                          clk,
	input  wire                          i_rst_n,
	input  wire mem_pkg::line_rd_req_t   i_icache_req,
	input  wire mem_pkg::line_rd_req_t   i_dcache_req,
	output logic                         o_icache_ready,
	output logic                         o_dcache_ready,
	output mem_pkg::line_t               o_line,
	input  wire mem_pkg::word_wr_req_t   i_wr_req,
	output logic                         o_wr_ack,
	output mem_pkg::line_rd_req_t        o_mem1_req,
	input  wire                          i_mem1_ready,
	input  wire mem_pkg::line_t          i_mem1_line,
	output mem_pkg::word_wr_req_t        o_mem2_req,
	input  wire                          i_mem2_ack,
	input  wire                          i_bus_request,
	output logic                         o_bus_grant
);

	import mem_pkg::*;

	logic owner_icache;
	logic icache_want;
	logic dcache_want;
	logic wr_want;

	// while its ready pulse is out a cache still shows the old request
	assign icache_want = i_icache_req.read && !o_icache_ready;
	assign dcache_want = i_dcache_req.read && !o_dcache_ready;
	// a pending bus request blocks new writes before the grant is up
	assign wr_want     = i_wr_req.write && !o_wr_ack && !o_bus_grant && !i_bus_request;

	// port 1, line reads
	always_ff @(posedge clk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			o_mem1_req     <= '0;
			owner_icache   <= 1'b0;
			o_icache_ready <= 1'b0;
			o_dcache_ready <= 1'b0;
		end else begin
			o_icache_ready <= 1'b0;
			o_dcache_ready <= 1'b0;
			if (o_mem1_req.read) begin
				// owner keeps the port until its line returns
				if (i_mem1_ready) begin
					o_mem1_req.read <= 1'b0;
					o_icache_ready  <= owner_icache;
					o_dcache_ready  <= !owner_icache;
				end
			end else if (icache_want) begin
				o_mem1_req   <= i_icache_req;
				owner_icache <= 1'b1;
			end else if (dcache_want) begin
				o_mem1_req   <= i_dcache_req;
				owner_icache <= 1'b0;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (o_mem1_req.read && i_mem1_ready) begin
			o_line <= i_mem1_line;
		end
	end

	// port 2 writes and the DMA bus grant
	always_ff @(posedge clk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			o_mem2_req  <= '0;
			o_wr_ack    <= 1'b0;
			o_bus_grant <= 1'b0;
		end else begin
			o_wr_ack <= 1'b0;
			if (o_mem2_req.write) begin
				if (i_mem2_ack) begin
					o_mem2_req.write <= 1'b0;
					o_wr_ack         <= 1'b1;
				end
			end else if (wr_want) begin
				o_mem2_req <= i_wr_req;
			end

			if (o_bus_grant) begin
				if (!i_bus_request) begin
					o_bus_grant <= 1'b0;
				end
			end else if (i_bus_request && !o_mem2_req.write) begin
				o_bus_grant <= 1'b1;
			end
		end
	end

	a_grant_excludes_write: assert property (@(posedge clk) disable iff (!i_rst_n)
		!(o_bus_grant && o_mem2_req.write));

	// owner is fixed for the whole line read
	a_owner_held: assert property (@(posedge clk) disable iff (!i_rst_n)
		o_mem1_req.read |=> $stable(owner_icache));

endmodule

`default_nettype wire

// ==== rtl/cache_subsystem.sv ====
`timescale 1ns/1ps
`default_nettype none

module cache_subsystem (
	input  wire                          clk,
	input  wire                          i_rst_n,
	// processor fetch port
	input  wire                          i_fetch_read,
	input  wire mem_pkg::word_t          i_fetch_addr,
	output logic                         o_fetch_ready,
	output mem_pkg::word_t               o_fetch_data,
	// processor data port
	input  wire                          i_data_read,
	input  wire                          i_data_write,
	input  wire mem_pkg::word_t          i_data_addr,
	input  wire mem_pkg::word_t          i_data_wdata,
	output logic                         o_data_ready,
	output mem_pkg::word_t               o_data_rdata,
	output logic                         o_data_ack,
	// memory port 1, line reads
	output mem_pkg::line_rd_req_t        o_mem1_req,
	input  wire                          i_mem1_ready,
	input  wire mem_pkg::line_t          i_mem1_line,
	// memory port 2, word writes
	output mem_pkg::word_wr_req_t        o_mem2_req,
	input  wire                          i_mem2_ack,
	// DMA bus handshake
	input  wire                          i_bus_request,
	output logic                         o_bus_grant
);

	import mem_pkg::*;

	line_rd_req_t icache_line_req;
	line_rd_req_t dcache_line_req;
	logic         icache_line_ready;
	logic         dcache_line_ready;
	line_t        refill_line;
	word_wr_req_t dcache_wr_req;
	logic         dcache_wr_ack;

	instr_cache u_instr_cache (
		.clk           (clk),
		.i_rst_n       (i_rst_n),
		.i_fetch_read  (i_fetch_read),
		.i_fetch_addr  (i_fetch_addr),
		.o_fetch_ready (o_fetch_ready),
		.o_fetch_data  (o_fetch_data),
		.o_line_req    (icache_line_req),
		.i_line_ready  (icache_line_ready),
		.i_line        (refill_line)
	);

	data_cache u_data_cache (
		.clk          (clk),
		.i_rst_n      (i_rst_n),
		.i_data_read  (i_data_read),
		.i_data_write (i_data_write),
		.i_data_addr  (i_data_addr),
		.i_data_wdata (i_data_wdata),
		.o_data_ready (o_data_ready),
		.o_data_rdata (o_data_rdata),
		.o_data_ack   (o_data_ack),
		.o_line_req   (dcache_line_req),
		.i_line_ready (dcache_line_ready),
		.i_line       (refill_line),
		.o_wr_req     (dcache_wr_req),
		.i_wr_ack     (dcache_wr_ack)
	);

	// both caches refill from the same registered line
	mem_port_arbiter u_mem_port_arbiter (
		.clk            (clk),
		.i_rst_n        (i_rst_n),
		.i_icache_req   (icache_line_req),
		.i_dcache_req   (dcache_line_req),
		.o_icache_ready (icache_line_ready),
		.o_dcache_ready (dcache_line_ready),
		.o_line         (refill_line),
		.i_wr_req       (dcache_wr_req),
		.o_wr_ack       (dcache_wr_ack),
		.o_mem1_req     (o_mem1_req),
		.i_mem1_ready   (i_mem1_ready),
		.i_mem1_line    (i_mem1_line),
		.o_mem2_req     (o_mem2_req),
		.i_mem2_ack     (i_mem2_ack),
		.i_bus_request  (i_bus_request),
		.o_bus_grant    (o_bus_grant)
	);

endmodule

`default_nettype wire

// ==== tb/tb_clock_gen.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen (
	output logic o_clk,
	output logic o_rst_n
);

	// 4 ns period
	initial begin
		o_clk = 1'b0;
		forever #2 o_clk = ~o_clk;
	end

	// reset held for 4 cycles, released on a falling edge
	initial begin
		o_rst_n = 1'b0;
		repeat (4) @(posedge o_clk);
		@(negedge o_clk);
		o_rst_n = 1'b1;
	end

endmodule

`default_nettype wire

// ==== tb/main_memory_model.sv ====
`timescale 1ns/1ps
`default_nettype none

module main_memory_model #(
	parameter int READ_LAT  = 5,
	parameter int WRITE_LAT = 3,
	parameter int DMA_HOLD  = 6
) (
	input  wire                          clk,
	input  wire mem_pkg::line_rd_req_t   i_mem1_req,
	output logic                         o_mem1_ready,
	output mem_pkg::line_t               o_mem1_line,
	input  wire mem_pkg::word_wr_req_t   i_mem2_req,
	output logic                         o_mem2_ack,
	input  wire                          i_dma_start,
	input  wire                          i_bus_grant,
	output logic                         o_bus_request
);

	import mem_pkg::*;

	word_t mem [0:65535];
	int    rd_cnt;
	int    wr_cnt;
	int    dma_cnt;
	logic  dma_start_q;

	// initial contents are the byte-swapped address xor a fixed pattern
	initial begin
		word_t addr;
		o_mem1_ready  = 1'b0;
		o_mem1_line   = '0;
		o_mem2_ack    = 1'b0;
		o_bus_request = 1'b0;
		rd_cnt        = 0;
		wr_cnt        = 0;
		dma_cnt       = 0;
		for (int a = 0; a < 65536; a++) begin
			addr   = word_t'(a);
			mem[a] = {addr[7:0], addr[15:8]} ^ 16'h5a3c;
		end
	end

	always @(posedge clk) begin
		dma_start_q <= i_dma_start;
	end

	// responses change on the falling edge, the DUT samples them on the rising one
	always @(negedge clk) begin
		o_mem1_ready = 1'b0;
		o_mem2_ack   = 1'b0;
		// the arbiter drops read right after ready, so a line is never sent twice
		if (i_mem1_req.read) begin
			rd_cnt = rd_cnt + 1;
			if (rd_cnt == READ_LAT) begin
				rd_cnt = 0;
				for (int w = 0; w < LINE_WORDS; w++) begin
					o_mem1_line[w*WORD_W +: WORD_W] = mem[i_mem1_req.addr + word_t'(w)];
				end
				o_mem1_ready = 1'b1;
			end
		end
		if (i_mem2_req.write) begin
			wr_cnt = wr_cnt + 1;
			if (wr_cnt == WRITE_LAT) begin
				wr_cnt                = 0;
				mem[i_mem2_req.addr] = i_mem2_req.data;
				o_mem2_ack            = 1'b1;
			end
		end
		// DMA master keeps the bus for DMA_HOLD granted cycles
		if (!o_bus_request) begin
			if (dma_start_q) begin
				o_bus_request = 1'b1;
				dma_cnt       = 0;
			end
		end else if (i_bus_grant) begin
			dma_cnt = dma_cnt + 1;
			if (dma_cnt == DMA_HOLD) begin
				o_bus_request = 1'b0;
			end
		end
	end

endmodule

`default_nettype wire

// ==== tb/tb_cache_subsystem.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_cache_subsystem;

	import mem_pkg::*;

	localparam int NUM_OPS        = 200;
	localparam int TIMEOUT_CYCLES = NUM_OPS * 40;

	logic         clk;
	logic         rst_n;
	logic         fetch_read;
	word_t        fetch_addr;
	logic         fetch_ready;
	word_t        fetch_data;
	logic         data_read;
	logic         data_write;
	word_t        data_addr;
	word_t        data_wdata;
	logic         data_ready;
	word_t        data_rdata;
	logic         data_ack;
	line_rd_req_t mem1_req;
	logic         mem1_ready;
	line_t        mem1_line;
	word_wr_req_t mem2_req;
	logic         mem2_ack;
	logic         bus_request;
	logic         bus_grant;
	logic         dma_start;

	int           mismatches;
	int           failures;
	int           cycle_count;
	logic         started;
	logic [31:0]  lcg_state;
	word_t        fetch_exp_addr;
	word_t        data_exp_addr;
	word_t        shadow [0:65535];

	tb_clock_gen u_clock_gen (
		.o_clk   (clk),
		.o_rst_n (rst_n)
	);

	main_memory_model #(
		.READ_LAT  (5),
		.WRITE_LAT (3)
	) u_memory (
		.clk           (clk),
		.i_mem1_req    (mem1_req),
		.o_mem1_ready  (mem1_ready),
		.o_mem1_line   (mem1_line),
		.i_mem2_req    (mem2_req),
		.o_mem2_ack    (mem2_ack),
		.i_dma_start   (dma_start),
		.i_bus_grant   (bus_grant),
		.o_bus_request (bus_request)
	);

	cache_subsystem u_cache_subsystem (
		.clk           (clk),
		.i_rst_n       (rst_n),
		.i_fetch_read  (fetch_read),
		.i_fetch_addr  (fetch_addr),
		.o_fetch_ready (fetch_ready),
		.o_fetch_data  (fetch_data),
		.i_data_read   (data_read),
		.i_data_write  (data_write),
		.i_data_addr   (data_addr),
		.i_data_wdata  (data_wdata),
		.o_data_ready  (data_ready),
		.o_data_rdata  (data_rdata),
		.o_data_ack    (data_ack),
		.o_mem1_req    (mem1_req),
		.i_mem1_ready  (mem1_ready),
		.i_mem1_line   (mem1_line),
		.o_mem2_req    (mem2_req),
		.i_mem2_ack    (mem2_ack),
		.i_bus_request (bus_request),
		.o_bus_grant   (bus_grant)
	);

	// memory word at addr before any write
	function automatic word_t ref_word(word_t addr);
		return {addr[7:0], addr[15:8]} ^ 16'h5a3c;
	endfunction

	function automatic logic [31:0] lcg_next(logic [31:0] state);
		return state * 32'd1103515245 + 32'd12345;
	endfunction

	task automatic check_equal(input word_t got, input word_t exp, input string what);
		if (got !== exp) begin
			mismatches++;
			$display("mismatch at %0d ns: %s, got %h, expected %h", $time, what, got, exp);
		end
	endtask

	task automatic report_failure(input string what);
		failures++;
		$display("error at %0d ns: %s", $time, what);
	endtask

	task automatic fetch_instr(input word_t addr, output int cycles);
		@(negedge clk);
		fetch_exp_addr = addr;
		fetch_addr     = addr;
		fetch_read     = 1'b1;
		started        = 1'b1;
		cycles         = 0;
		do begin
			@(negedge clk);
			cycles++;
		end while (!fetch_ready);
		fetch_read = 1'b0;
	endtask

	task automatic load_word(input word_t addr);
		@(negedge clk);
		data_exp_addr = addr;
		data_addr     = addr;
		data_read     = 1'b1;
		started       = 1'b1;
		do begin
			@(negedge clk);
		end while (!data_ready);
		data_read = 1'b0;
	endtask

	task automatic store_word(input word_t addr, input word_t data);
		@(negedge clk);
		data_addr  = addr;
		data_wdata = data;
		data_write = 1'b1;
		started    = 1'b1;
		do begin
			@(negedge clk);
		end while (!data_ack);
		data_write   = 1'b0;
		shadow[addr] = data;
		check_equal(u_memory.mem[addr], data, "memory word after write");
	endtask

	// outputs are stable on the falling edge
	always @(negedge clk) begin
		if (rst_n) begin
			if (!started && (fetch_ready || data_ready || data_ack || mem1_req.read ||
					mem2_req.write || bus_grant)) begin
				report_failure("output active before the first processor request");
			end
			if (fetch_ready) begin
				check_equal(fetch_data, shadow[fetch_exp_addr], "fetch data");
			end
			if (data_ready) begin
				check_equal(data_rdata, shadow[data_exp_addr], "data read");
			end
			if (bus_grant && mem2_req.write) begin
				report_failure("port 2 write while the DMA bus is granted");
			end
		end
	end

	initial begin
		cycle_count = 0;
		while (cycle_count < TIMEOUT_CYCLES) begin
			@(posedge clk);
			cycle_count++;
		end
		$display("timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
		$display("errors: %0d mismatches, %0d other failures", mismatches, failures + 1);
		$display("RESULT: FAIL");
		$finish;
	end

	initial begin
		int         cycles;
		word_t      f_addr;
		word_t      d_addr;
		word_t      d_data;
		logic [1:0] kind;
		fetch_read     = 1'b0;
		fetch_addr     = '0;
		data_read      = 1'b0;
		data_write     = 1'b0;
		data_addr      = '0;
		data_wdata     = '0;
		dma_start      = 1'b0;
		started        = 1'b0;
		mismatches     = 0;
		failures       = 0;
		lcg_state      = 32'h61d;
		fetch_exp_addr = '0;
		data_exp_addr  = '0;
		for (int a = 0; a < 65536; a++) begin
			shadow[a] = ref_word(word_t'(a));
		end
		@(posedge rst_n);
		// quiet outputs after reset
		repeat (6) @(negedge clk);

		// a miss and then a hit in the same line
		fetch_instr(16'h0124, cycles);
		fetch_instr(16'h0126, cycles);
		check_equal(word_t'(cycles), 16'd2, "fetch hit latency in cycles");

		// write on a hit and then write on a miss
		load_word(16'h8040);
		store_word(16'h8041, 16'hbeef);
		load_word(16'h8041);
		store_word(16'h8a52, 16'h1357);
		load_word(16'h8a52);

		// same index with different tags and both caches missing together
		fork
			fetch_instr(16'h0010, cycles);
			load_word(16'h8010);
		join
		fork
			fetch_instr(16'h0410, cycles);
			load_word(16'h0810);
		join
		fetch_instr(16'h0010, cycles);
		load_word(16'h8010);

		// DMA grant holds back a write until the bus is released
		@(negedge clk);
		dma_start = 1'b1;
		@(negedge clk);
		dma_start = 1'b0;
		while (!bus_grant) begin
			@(negedge clk);
		end
		store_word(16'h8100, 16'ha5c3);
		load_word(16'h8100);

		for (int i = 0; i < NUM_OPS; i++) begin
			lcg_state = lcg_next(lcg_state);
			f_addr    = {9'b0, lcg_state[22:16]};
			d_addr    = 16'h8000 | {9'b0, lcg_state[29:23]};
			lcg_state = lcg_next(lcg_state);
			d_data    = lcg_state[31:16];
			kind      = lcg_state[9:8];
			case (kind)
				2'd0: fetch_instr(f_addr, cycles);
				2'd1: load_word(d_addr);
				2'd2: store_word(d_addr, d_data);
				default: begin
					fork
						fetch_instr(f_addr, cycles);
						load_word(d_addr);
					join
				end
			endcase
		end

		repeat (4) @(negedge clk);
		$display("errors: %0d mismatches, %0d other failures", mismatches, failures);
		if (mismatches == 0 && failures == 0) begin
			$display("RESULT: PASS");
		end else begin
			$display("RESULT: FAIL");
		end
		$finish;
	end

endmodule

`default_nettype wire

// ==== files.f ====
rtl/mem_pkg.sv
rtl/instr_cache.sv
rtl/data_cache.sv
rtl/mem_port_arbiter.sv
rtl/cache_subsystem.sv
tb/tb_clock_gen.sv
tb/main_memory_model.sv
tb/tb_cache_subsystem.sv

// ==== run.sh ====
#!/bin/sh
# build and run the cache subsystem testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module tb_cache_subsystem \
	-f files.f -o tb_cache_subsystem
if [ $? -ne 0 ]; then
	echo "build failed"
	exit 1
fi

output=$(./obj_dir/tb_cache_subsystem)
status=$?
printf '%s\n' "$output"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if printf '%s\n' "$output" | grep -q '^RESULT: PASS$'; then
	exit 0
fi
exit 1
